//--- hdl/dac_ctrl_pkg.sv
/* Types and constants shared by the DAC controller and its testbench
   Register space is 32 addresses of 8 bits, reached by 16-bit SPI frames */
package dac_ctrl_pkg;

	////////////////////////////////////////
	// Widths with a meaning

	// One signed channel sample
	typedef logic signed [15:0] dac_sample_t;

	// Half-cycle value of the 18 lanes
	// Bit 17 sample clock, bit 16 data clock, bits 15..0 data
	typedef logic [17:0] lane_word_t;

	typedef logic [4:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// SPI frame as sent MSB first
	typedef struct packed {
		logic      rw;
		logic [1:0] pad;
		reg_addr_t addr;
		reg_data_t data;
	} spi_frame_t;

	////////////////////////////////////////
	// APB slave port

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [15:0] paddr;
		logic [15:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [15:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// Sequencer states
	typedef enum logic [3:0] {
		reset_pulse,
		reset_release,
		delay_load,
		delay_send,
		delay_wait,
		idle,
		cmd_send,
		cmd_wait,
		cmd_done
	} seq_state_t;

	////////////////////////////////////////
	// Register map and framing

	localparam reg_addr_t SMP_DLY_ADDR = 5'd5;
	localparam logic [7:0] GET_PAGE = 8'h20;
	localparam logic [7:0] SET_PAGE = 8'h21;

	// Channel markers on the two clock lanes
	localparam logic [1:0] MARK_CH0 = 2'b01;
	localparam logic [1:0] MARK_CH1 = 2'b10;

endpackage

//--- hdl/dac_lane_framer.sv
/* DDR lane output at the system clock rate, channel 0 in the high half
   Lanes are single-ended here; differential pad buffers sit in a board wrapper */
`timescale 1ns/1ns

module dac_lane_framer (
	input  logic                      clk_in,
	input  logic                      rst_n,
	input  dac_ctrl_pkg::dac_sample_t dac0,
	input  dac_ctrl_pkg::dac_sample_t dac1,
	output logic                      dac_clk,
	output logic                      dac_dci,
	output logic [15:0]               dac_d
);
	import dac_ctrl_pkg::*;

	// Word pair of one sample period
	typedef struct packed {
		lane_word_t ch1;
		lane_word_t ch0;
	} lane_pair_t;

	lane_pair_t pair_q;
	lane_pair_t out_q;
	lane_word_t lo_q;
	lane_word_t lane_out;

	////////////////////////////////////////
	// Rising edge stages

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			pair_q <= '0;
			out_q  <= '0;
		end else begin
			// Frame samples with channel markers
			pair_q.ch0 <= {MARK_CH0, dac0};
			pair_q.ch1 <= {MARK_CH1, dac1};
			// Hold pair for the output cycle
			out_q <= pair_q;
		end
	end

	// Channel 1 word moves on the falling edge
	// so it stays put for the whole low half
	always_ff @(negedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			lo_q <= '0;
		end else begin
			lo_q <= out_q.ch1;
		end
	end

	// DDR select by clock phase
	assign lane_out = clk_in ? out_q.ch0 : lo_q;

	// Lane split
	assign dac_clk = lane_out[17];
	assign dac_dci = lane_out[16];
	assign dac_d   = lane_out[15:0];

endmodule

//--- hdl/spi_master.sv
/* Mode 0 SPI master for 16-bit frames, one transfer at a time
   SPI_CLK_DIV system clocks per half-period; start is ignored while busy */
`timescale 1ns/1ns

module spi_master #(
	parameter int SPI_CLK_DIV = 5
) (
	input  logic                     clk_in,
	input  logic                     rst_n,
	input  logic                     start,
	input  dac_ctrl_pkg::spi_frame_t frame,
	output logic                     busy,
	output dac_ctrl_pkg::reg_data_t  rx_data,
	output logic                     spi_cs_n,
	output logic                     spi_sck,
	output logic                     spi_sdo,
	input  logic                     spi_sdi
);
	import dac_ctrl_pkg::*;

	localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);

	logic [DIV_W-1:0] div_cnt_q;
	logic [3:0]       bit_cnt_q;
	logic [15:0]      shift_q;
	logic             sdi_q;
	reg_data_t        rx_q;

	logic half_tick;
	logic fall_tick;
	logic last_bit;
	logic launch;

	// Half-period boundary of the SPI clock
	assign half_tick = busy && (div_cnt_q == DIV_LAST);
	// sck about to fall
	assign fall_tick = half_tick && spi_sck;
	assign last_bit  = (bit_cnt_q == 4'd15);
	assign launch    = start && !busy;

	////////////////////////////////////////
	// Control and clock generation

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			spi_cs_n  <= 1'b1;
			spi_sck   <= 1'b0;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else if (launch) begin
			// Chip select drops with busy
			busy      <= 1'b1;
			spi_cs_n  <= 1'b0;
			div_cnt_q <= '0;
			bit_cnt_q <= '0;
		end else if (half_tick) begin
			div_cnt_q <= '0;
			spi_sck   <= ~spi_sck;
			if (fall_tick) begin
				bit_cnt_q <= bit_cnt_q + 4'd1;
				// Frame ends on the 16th falling edge
				if (last_bit) begin
					busy     <= 1'b0;
					spi_cs_n <= 1'b1;
				end
			end
		end else if (busy) begin
			div_cnt_q <= div_cnt_q + DIV_W'(1);
		end
	end

	////////////////////////////////////////
	// Data path

	always_ff @(posedge clk_in) begin
		if (launch) begin
			shift_q <= frame;
		end else if (half_tick) begin
			if (!spi_sck) begin
				// Rising edge, sample input
				sdi_q <= spi_sdi;
			end else begin
				// Falling edge, next bit out and sampled bit in
				shift_q <= {shift_q[14:0], sdi_q};
				if (last_bit) begin
					rx_q <= {shift_q[6:0], sdi_q};
				end
			end
		end
	end

	// MSB first
	assign spi_sdo = shift_q[15];
	// Last eight bits of the frame, held until the next one
	assign rx_data = rx_q;

endmodule

//--- hdl/dac_reg_sequencer.sv
/* DAC power-up sequence, then register get and set from an APB slave port
   Get at page 0x20 (read), set at page 0x21 (write), paddr[4:0] names the register
   RESET_CYCLES must be at least 1; other pages fail at once with pslverr */
`timescale 1ns/1ns

module dac_reg_sequencer #(
	parameter dac_ctrl_pkg::reg_data_t SMP_DLY      = '0,
	parameter int                      RESET_CYCLES = 255
) (
	input  logic                     clk_in,
	input  logic                     rst_n,
	input  dac_ctrl_pkg::apb_req_t   apb_req,
	output dac_ctrl_pkg::apb_rsp_t   apb_rsp,
	output logic                     dac_reset,
	output logic                     spi_start,
	output dac_ctrl_pkg::spi_frame_t spi_frame,
	input  logic                     spi_busy,
	input  dac_ctrl_pkg::reg_data_t  spi_rx
);
	import dac_ctrl_pkg::*;

	localparam int CNT_W = (RESET_CYCLES > 1) ? $clog2(RESET_CYCLES) : 1;

	seq_state_t       state_q;
	logic [CNT_W-1:0] rst_cnt_q;
	spi_frame_t       frame_q;
	logic             start_q;
	logic             reset_q;
	logic             ack_q;
	logic [15:0]      prdata_q;

	logic [7:0] page;
	logic       access;
	logic       is_get;
	logic       is_set;
	logic       bad_access;

	////////////////////////////////////////
	// APB decode

	assign page   = apb_req.paddr[15:8];
	// Access phase of a transfer
	assign access = apb_req.psel && apb_req.penable;
	assign is_get = access && !apb_req.pwrite && (page == GET_PAGE);
	assign is_set = access && apb_req.pwrite && (page == SET_PAGE);

	// Unknown page or wrong direction, answered in the same cycle
	assign bad_access = (state_q == idle) && access && !is_get && !is_set;

	////////////////////////////////////////
	// Sequencer FSM

	always_ff @(posedge clk_in or negedge rst_n) begin
		if (!rst_n) begin
			state_q   <= reset_pulse;
			rst_cnt_q <= CNT_W'(RESET_CYCLES - 1);
			frame_q   <= '0;
			start_q   <= 1'b0;
			reset_q   <= 1'b1;
			ack_q     <= 1'b0;
			prdata_q  <= '0;
		end else begin
			case (state_q)
				// DAC reset held for RESET_CYCLES clocks
				reset_pulse: begin
					if (rst_cnt_q == '0) begin
						reset_q <= 1'b0;
						state_q <= reset_release;
					end else begin
						rst_cnt_q <= rst_cnt_q - CNT_W'(1);
					end
				end
				// One clock of margin after reset
				reset_release: begin
					state_q <= delay_load;
				end
				// Sample delay write
				delay_load: begin
					frame_q.rw   <= 1'b0;
					frame_q.pad  <= 2'b00;
					frame_q.addr <= SMP_DLY_ADDR;
					frame_q.data <= SMP_DLY;
					start_q      <= 1'b1;
					state_q      <= delay_send;
				end
				// busy only shows up next cycle
				delay_send: begin
					start_q <= 1'b0;
					state_q <= delay_wait;
				end
				delay_wait: begin
					if (!spi_busy) begin
						state_q <= idle;
					end
				end
				// Wait for a get or set
				idle: begin
					if (is_get || is_set) begin
						frame_q.rw   <= !apb_req.pwrite;
						frame_q.pad  <= 2'b00;
						frame_q.addr <= apb_req.paddr[4:0];
						// Data byte is don't care on a read
						frame_q.data <= apb_req.pwrite ? apb_req.pwdata[7:0] : 8'h00;
						start_q      <= 1'b1;
						state_q      <= cmd_send;
					end
				end
				cmd_send: begin
					start_q <= 1'b0;
					state_q <= cmd_wait;
				end
				// rx byte valid once busy falls
				cmd_wait: begin
					if (!spi_busy) begin
						prdata_q <= frame_q.rw ? {8'h00, spi_rx} : 16'h0000;
						ack_q    <= 1'b1;
						state_q  <= cmd_done;
					end
				end
				// pready up for this one cycle
				cmd_done: begin
					ack_q   <= 1'b0;
					state_q <= idle;
				end
				default: begin
					start_q <= 1'b0;
					ack_q   <= 1'b0;
					state_q <= idle;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Outputs

	assign dac_reset = reset_q;
	assign spi_start = start_q;
	assign spi_frame = frame_q;

	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pready  = ack_q || bad_access;
	assign apb_rsp.pslverr = bad_access;

endmodule

//--- hdl/dac_ctrl_top.sv
/* Dual-channel DAC controller, DDR sample lanes plus SPI register access over APB
   APB transfers stall in the access phase until power-up sequencing is done */
`timescale 1ns/1ns

module dac_ctrl_top #(
	parameter dac_ctrl_pkg::reg_data_t SMP_DLY      = '0,
	parameter int                      RESET_CYCLES = 255,
	parameter int                      SPI_CLK_DIV  = 5
) (
	input  logic                      clk_in,
	input  logic                      rst_n,
	input  dac_ctrl_pkg::dac_sample_t dac0,
	input  dac_ctrl_pkg::dac_sample_t dac1,
	input  dac_ctrl_pkg::apb_req_t    apb_req,
	output dac_ctrl_pkg::apb_rsp_t    apb_rsp,
	output logic                      dac_clk,
	output logic                      dac_dci,
	output logic [15:0]               dac_d,
	output logic                      dac_reset,
	output logic                      spi_cs_n,
	output logic                      spi_sck,
	output logic                      spi_sdo,
	input  logic                      spi_sdi
);
	import dac_ctrl_pkg::*;

	// Sequencer to SPI master
	logic       spi_start;
	spi_frame_t spi_frame;
	logic       spi_busy;
	reg_data_t  spi_rx;

	////////////////////////////////////////
	// Sample path

	dac_lane_framer framer_i (
		.clk_in  (clk_in),
		.rst_n   (rst_n),
		.dac0    (dac0),
		.dac1    (dac1),
		.dac_clk (dac_clk),
		.dac_dci (dac_dci),
		.dac_d   (dac_d)
	);

	////////////////////////////////////////
	// Configuration path

	dac_reg_sequencer #(
		.SMP_DLY      (SMP_DLY),
		.RESET_CYCLES (RESET_CYCLES)
	) sequencer_i (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.dac_reset (dac_reset),
		.spi_start (spi_start),
		.spi_frame (spi_frame),
		.spi_busy  (spi_busy),
		.spi_rx    (spi_rx)
	);

	spi_master #(
		.SPI_CLK_DIV (SPI_CLK_DIV)
	) spi_i (
		.clk_in   (clk_in),
		.rst_n    (rst_n),
		.start    (spi_start),
		.frame    (spi_frame),
		.busy     (spi_busy),
		.rx_data  (spi_rx),
		.spi_cs_n (spi_cs_n),
		.spi_sck  (spi_sck),
		.spi_sdo  (spi_sdo),
		.spi_sdi  (spi_sdi)
	);

endmodule

//--- tests/tb_dac_ctrl.sv
/* Testbench for dac_ctrl_top with a behavioral SPI register model of the DAC
   Runs with a short DAC reset pulse and a fast SPI clock */
`timescale 1ns/1ns

module tb_dac_ctrl;
	import dac_ctrl_pkg::*;

	localparam int        RESET_CYCLES = 20;
	localparam int        SPI_CLK_DIV  = 2;
	localparam reg_data_t SMP_DLY      = 8'h0b;
	localparam int        APB_TIMEOUT  = 400;
	localparam int        NUM_SAMPLES  = 64;

	logic        clk_in;
	logic        rst_n;
	dac_sample_t dac0;
	dac_sample_t dac1;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        dac_clk;
	logic        dac_dci;
	logic [15:0] dac_d;
	logic        dac_reset;
	logic        spi_cs_n;
	logic        spi_sck;
	logic        spi_sdo;
	logic        spi_sdi;

	// SPI register model state
	reg_data_t   model_mem [32];
	logic [15:0] mdl_shift;
	int          mdl_bits;
	logic        mdl_rw;
	reg_addr_t   mdl_addr;
	logic        cs_prev;
	logic        sck_prev;
	int          frame_starts;
	int          frames_done;
	spi_frame_t  first_frame;
	spi_frame_t  last_frame;

	logic [31:0] lcg_state = 32'd6059;
	// Expected lane pairs with the channel 1 word in the upper half
	logic [35:0] exp_q [$];

	dac_ctrl_top #(
		.SMP_DLY      (SMP_DLY),
		.RESET_CYCLES (RESET_CYCLES),
		.SPI_CLK_DIV  (SPI_CLK_DIV)
	) dut_i (
		.clk_in    (clk_in),
		.rst_n     (rst_n),
		.dac0      (dac0),
		.dac1      (dac1),
		.apb_req   (apb_req),
		.apb_rsp   (apb_rsp),
		.dac_clk   (dac_clk),
		.dac_dci   (dac_dci),
		.dac_d     (dac_d),
		.dac_reset (dac_reset),
		.spi_cs_n  (spi_cs_n),
		.spi_sck   (spi_sck),
		.spi_sdo   (spi_sdo),
		.spi_sdi   (spi_sdi)
	);

	// 8 ns clock
	initial begin
		clk_in = 1'b0;
		forever begin
			#4;
			clk_in = ~clk_in;
		end
	end

	////////////////////////////////////////
	// Helpers

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Test failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("Timeout at %0t ns: %s", $time, what);
		$display("Test failed");
		$fatal(1, "Stopped on timeout");
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Lane pair for two samples with markers on the two clock lanes
	function automatic logic [35:0] ref_pair(input dac_sample_t s0, input dac_sample_t s1);
		return {MARK_CH1, s1, MARK_CH0, s0};
	endfunction

	////////////////////////////////////////
	// SPI register model on the falling system clock edge

	initial begin
		for (int i = 0; i < 32; i++) begin
			// Distinct byte per address
			model_mem[i] = 8'(i * 37 + 11);
		end
		frame_starts = 0;
		frames_done  = 0;
		first_frame  = '0;
		last_frame   = '0;
	end

	always @(negedge clk_in) begin
		logic [2:0] bit_idx;
		if (!rst_n) begin
			cs_prev  = 1'b1;
			sck_prev = 1'b0;
			mdl_bits = 0;
			mdl_rw   = 1'b0;
			spi_sdi <= 1'b0;
		end else if (spi_cs_n) begin
			// End of a frame
			if (!cs_prev) begin
				check_eq(mdl_bits, 16, "SPI bits in one frame");
				last_frame = spi_frame_t'(mdl_shift);
				if (frames_done == 0) begin
					first_frame = last_frame;
				end
				if (!last_frame.rw) begin
					model_mem[last_frame.addr] = last_frame.data;
				end
				frames_done++;
			end
			mdl_bits = 0;
			mdl_rw   = 1'b0;
			spi_sdi <= 1'b0;
		end else begin
			if (cs_prev) begin
				frame_starts++;
				check_eq(32'(dac_reset), 0, "SPI frame start while dac_reset high");
			end
			if (spi_sck && !sck_prev) begin
				mdl_shift = {mdl_shift[14:0], spi_sdo};
				mdl_bits++;
				// Command byte complete
				if (mdl_bits == 8) begin
					mdl_rw   = mdl_shift[7];
					mdl_addr = mdl_shift[4:0];
				end
			end else if (!spi_sck && sck_prev && mdl_rw && mdl_bits >= 8 && mdl_bits < 16) begin
				// Read data out MSB first
				bit_idx = 3'(15 - mdl_bits);
				spi_sdi <= model_mem[mdl_addr][bit_idx];
			end
		end
		cs_prev  = spi_cs_n;
		sck_prev = spi_sck;
	end

	////////////////////////////////////////
	// APB transfers

	task automatic apb_xfer(input logic write, input logic [15:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		int waited;
		waited = 0;
		// Setup phase
		@(negedge clk_in);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= write;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		// Access phase held until pready
		@(negedge clk_in);
		apb_req.penable <= 1'b1;
		#2;
		while (!apb_rsp.pready) begin
			@(negedge clk_in);
			#2;
			waited++;
			if (waited > APB_TIMEOUT) begin
				stop_on_timeout("APB transfer never saw pready");
			end
		end
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(negedge clk_in);
		apb_req <= '0;
		#2;
		check_eq(32'(apb_rsp.pready), 0, "pready after transfer end");
	endtask

	task automatic set_random_reg(input int new_frames, output reg_addr_t addr);
		logic [31:0] ra;
		logic [31:0] rd;
		logic [15:0] rdata;
		logic        err;
		int          frames_before;
		ra = lcg_next();
		rd = lcg_next();
		frames_before = frames_done;
		apb_xfer(1'b1, {SET_PAGE, ra[31:24]}, rd[31:16], rdata, err);
		addr = ra[28:24];
		check_eq(32'(err), 0, "pslverr on register set");
		check_eq(frames_done, frames_before + new_frames, "SPI frames for register set");
		check_eq(32'(last_frame.rw), 0, "set frame direction");
		check_eq(32'(last_frame.addr), 32'(addr), "set frame address");
		check_eq(32'(last_frame.data), 32'(rd[23:16]), "set frame data");
	endtask

	task automatic get_reg(input reg_addr_t addr);
		logic [31:0] r;
		logic [15:0] rdata;
		logic        err;
		int          frames_before;
		r = lcg_next();
		frames_before = frames_done;
		// Address bits above the register number carry noise
		apb_xfer(1'b0, {GET_PAGE, r[31:29], addr}, r[23:8], rdata, err);
		check_eq(32'(err), 0, "pslverr on register get");
		check_eq(frames_done, frames_before + 1, "SPI frames for register get");
		check_eq(32'(last_frame.rw), 1, "get frame direction");
		check_eq(32'(last_frame.addr), 32'(addr), "get frame address");
		check_eq(32'(rdata), 32'({8'h00, model_mem[addr]}), "prdata of register get");
	endtask

	task automatic bad_access(input logic write, input logic [7:0] page);
		logic [31:0] r;
		logic [15:0] rdata;
		logic        err;
		int          starts_before;
		r = lcg_next();
		starts_before = frame_starts;
		apb_xfer(write, {page, r[31:24]}, r[23:8], rdata, err);
		// Room for a stray frame to show up
		repeat (4) @(negedge clk_in);
		#2;
		check_eq(32'(err), 1, "pslverr on unknown access");
		check_eq(frame_starts, starts_before, "SPI frames after unknown access");
	endtask

	////////////////////////////////////////
	// Sample lanes

	task automatic drive_samples(input int count);
		logic [31:0] r0;
		logic [31:0] r1;
		for (int i = 0; i < count; i++) begin
			@(negedge clk_in);
			r0 = lcg_next();
			r1 = lcg_next();
			dac0 <= dac_sample_t'(r0[31:16]);
			dac1 <= dac_sample_t'(r1[31:16]);
			exp_q.push_back(ref_pair(r0[31:16], r1[31:16]));
		end
	endtask

	task automatic compare_lanes(input int count);
		logic [35:0] exp_pair;
		int          waited;
		waited = 0;
		@(posedge clk_in);
		#2;
		// Head pair is two edges old once a second pair is queued
		while (exp_q.size() < 2) begin
			waited++;
			if (waited > 10) begin
				stop_on_timeout("no samples queued for the lane check");
			end
			@(posedge clk_in);
			#2;
		end
		for (int i = 0; i < count - 1; i++) begin
			exp_pair = exp_q[0];
			check_eq(32'({dac_clk, dac_dci, dac_d}), 32'(exp_pair[17:0]), "high half lanes");
			@(negedge clk_in);
			#2;
			check_eq(32'({dac_clk, dac_dci, dac_d}), 32'(exp_pair[35:18]), "low half lanes");
			void'(exp_q.pop_front());
			@(posedge clk_in);
			#2;
		end
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		reg_addr_t   set_addrs [$];
		reg_addr_t   addr;
		logic [31:0] r;
		logic [7:0]  page;
		int          waited;
		rst_n = 1'b1;
		apb_req <= '0;
		dac0    <= '0;
		dac1    <= '0;
		spi_sdi <= 1'b0;
		#1;
		rst_n = 1'b0;
		repeat (4) @(posedge clk_in);
		@(negedge clk_in);
		rst_n = 1'b1;
		#2;
		check_eq(32'(dac_reset), 1, "dac_reset after reset");
		check_eq(32'(apb_rsp.pready), 0, "pready after reset");
		check_eq(32'(apb_rsp.pslverr), 0, "pslverr after reset");
		check_eq(32'(spi_sck), 0, "spi_sck after reset");
		check_eq(32'(spi_cs_n), 1, "spi_cs_n after reset");
		// DAC reset pulse
		waited = 0;
		while (dac_reset) begin
			@(negedge clk_in);
			#2;
			waited++;
			if (waited > RESET_CYCLES + 8) begin
				stop_on_timeout("dac_reset never fell");
			end
		end
		// First set stalls behind the sample delay write
		set_random_reg(2, addr);
		set_addrs.push_back(addr);
		check_eq(32'(first_frame.rw), 0, "power-up frame direction");
		check_eq(32'(first_frame.addr), 32'(SMP_DLY_ADDR), "power-up frame address");
		check_eq(32'(first_frame.data), 32'(SMP_DLY), "power-up frame data");
		for (int i = 0; i < 7; i++) begin
			set_random_reg(1, addr);
			set_addrs.push_back(addr);
		end
		// Read back
		get_reg(SMP_DLY_ADDR);
		foreach (set_addrs[i]) begin
			get_reg(set_addrs[i]);
		end
		for (int i = 0; i < 4; i++) begin
			r = lcg_next();
			get_reg(r[31:27]);
		end
		// Wrong direction then unknown pages
		bad_access(1'b1, GET_PAGE);
		bad_access(1'b0, SET_PAGE);
		for (int i = 0; i < 4; i++) begin
			r = lcg_next();
			page = r[31:24];
			if (page == GET_PAGE || page == SET_PAGE) begin
				page = page ^ 8'h80;
			end
			bad_access(r[23], page);
		end
		fork
			drive_samples(NUM_SAMPLES);
			compare_lanes(NUM_SAMPLES);
		join
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- dac_ctrl_top.f
hdl/dac_ctrl_pkg.sv
hdl/dac_lane_framer.sv
hdl/spi_master.sv
hdl/dac_reg_sequencer.sv
hdl/dac_ctrl_top.sv
tests/tb_dac_ctrl.sv

//--- Makefile
# Verilator build and run of the DAC controller testbench
# Any variable can be overridden on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dac_ctrl
FILELIST  ?= dac_ctrl_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
EXTRA     ?=

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: sim clean

# Exit status of the simulation binary is the pass/fail result
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) $(EXTRA) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
